// File: all.f
src/vpu_pkg.sv
src/vpu_ctrl_if.sv
src/vpu_ctrl.sv
src/vpu_addr_gen.sv
src/vpu_node_calc.sv
src/vpu_top.sv
verif/tb_clk_gen.sv
verif/vpu_tb.sv

// File: verif/vpu_tb.sv
`timescale 1ns/1ps

module vpu_tb;
    import vpu_pkg::*;

    localparam int LOAD_CYCLES   = 40;
    localparam int RESET_TIMEOUT = 20;
    localparam int DONE_TIMEOUT  = 10;
    localparam int VAR_TIMEOUT   = 300;
    // enables trail the one-sweep request by three cycles
    localparam int VAR_WR_FIRST  = 3;
    localparam int VAR_WR_LAST   = VAR_WR_FIRST + LAST_ADDR;
    localparam int VAR_DONE_CYC  = VAR_WR_LAST + 2;

    logic                       clk;
    logic                       reset_n;
    logic                       start;
    logic                       load_en;
    logic                       check_go;
    logic                       var_go;
    logic                       check_wr;
    logic [N_EDGE*ADDR_W-1:0]   chk_base;
    logic [N_EDGE*MSG_W-1:0]    msg_in;
    msg_t                       llr_in;
    logic [N_EDGE*MSG_W-1:0]    msg_out;
    logic                       hard_bit;
    logic                       check_en;
    logic                       check_done;
    logic                       var_done;
    logic                       ram_wren;
    logic [N_EDGE*ADDR_W-1:0]   ram_addr;
    logic                       lram_wren;
    addr_t                      lram_addr;
    vpu_state_e                 state;

    integer                     seed;
    int                         n;
    int                         c;
    logic                       le;
    logic                       wren_m;
    logic                       done_seen;
    logic                       exp_hard;
    addr_t                      addr_m;
    addr_t                      edge_ofs;
    addr_t                      llr_ofs;
    msg_t                       llr_v;
    logic [N_EDGE*MSG_W-1:0]    msg_v;
    logic [N_EDGE*MSG_W-1:0]    exp_msg;
    logic [N_EDGE*MSG_W-1:0]    prev_msg;
    logic [N_EDGE*MSG_W-1:0]    held_msg;

    tb_clk_gen clk_gen_i (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    vpu_top dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start),
        .load_en_i    (load_en),
        .check_go_i   (check_go),
        .var_go_i     (var_go),
        .check_wr_i   (check_wr),
        .chk_base_i   (chk_base),
        .msg_i        (msg_in),
        .llr_i        (llr_in),
        .msg_o        (msg_out),
        .hard_bit_o   (hard_bit),
        .check_en_o   (check_en),
        .check_done_o (check_done),
        .var_done_o   (var_done),
        .ram_wren_o   (ram_wren),
        .ram_addr_o   (ram_addr),
        .lram_wren_o  (lram_wren),
        .lram_addr_o  (lram_addr),
        .state_o      (state)
    );

    task automatic step();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: %s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped after a timeout");
    endtask

    task automatic check_lanes(input logic [N_EDGE*ADDR_W-1:0] b, input addr_t off);
        addr_t e;
        for (int i = 0; i < N_EDGE; i++) begin
            e = b[i*ADDR_W +: ADDR_W] + off;
            check_equal($sformatf("ram_addr lane %0d", i), ram_addr[i*ADDR_W +: ADDR_W], e);
        end
    endtask

    function automatic int msg_value(input msg_t m);
        int mag;
        mag = m[MSG_W-2:0];
        return m[MSG_W-1] ? -mag : mag;
    endfunction

    function automatic msg_t sign_mag_sat(input int v);
        int   mag;
        msg_t r;
        mag = (v < 0) ? -v : v;
        if (mag > SAT_MAG)
            mag = SAT_MAG;
        r = {(v < 0), mag[MSG_W-2:0]};
        return r;
    endfunction

    // random node inputs plus the expected extrinsic outputs
    task automatic drive_node();
        int total;
        int mv [N_EDGE];
        msg_v  = $random(seed);
        llr_v  = $random(seed);
        msg_in = msg_v;
        llr_in = llr_v;
        total  = $signed(llr_v);
        for (int i = 0; i < N_EDGE; i++) begin
            mv[i] = msg_value(msg_v[i*MSG_W +: MSG_W]);
            total = total + mv[i];
        end
        for (int i = 0; i < N_EDGE; i++)
            exp_msg[i*MSG_W +: MSG_W] = sign_mag_sat(total - mv[i]);
        exp_hard = (total < 0);
    endtask

    initial begin
        seed     = 32'h57e0_cb6e;
        start    = 1'b0;
        load_en  = 1'b0;
        check_go = 1'b0;
        var_go   = 1'b0;
        check_wr = 1'b0;
        chk_base = '0;
        msg_in   = '0;
        llr_in   = '0;
        n = 0;
        while (reset_n !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > RESET_TIMEOUT)
                fail_timeout("reset was never released");
        end

        check_equal("state", state, ST_IDLE);
        check_equal("ram_wren", ram_wren, 1'b0);
        check_equal("lram_wren", lram_wren, 1'b0);
        check_equal("check_en", check_en, 1'b0);
        check_equal("check_done", check_done, 1'b0);
        check_equal("var_done", var_done, 1'b0);
        check_equal("lram_addr", lram_addr, 0);
        check_equal("msg_out", msg_out, 0);
        check_lanes('0, 8'd0);

        ////////////////////////////////////////
        // load phase
        start = 1'b1;
        step();
        start = 1'b0;
        check_equal("state", state, ST_LOAD);
        addr_m = '0;
        wren_m = 1'b0;
        repeat (LOAD_CYCLES) begin
            le      = $random(seed);
            load_en = le;
            step();
            addr_m = addr_m + wren_m;
            wren_m = le;
            check_equal("ram_wren", ram_wren, le);
            check_equal("lram_wren", lram_wren, le);
            check_equal("lram_addr", lram_addr, addr_m);
            check_lanes('0, addr_m);
        end
        load_en = 1'b0;

        ////////////////////////////////////////
        // check phase, 256 writes
        edge_ofs = '0;
        llr_ofs  = '0;
        chk_base = $random(seed);
        check_go = 1'b1;
        step();
        check_go = 1'b0;
        check_equal("state", state, ST_CHECK);
        check_equal("check_en", check_en, 1'b0);
        check_lanes(chk_base, edge_ofs);
        step();
        check_equal("check_en", check_en, 1'b1);
        check_lanes(chk_base, addr_t'(edge_ofs + 1));
        // check enable drops two cycles after the cycle count hits 255
        n = 1;
        repeat (LAST_ADDR + 1) begin
            check_wr = 1'b1;
            step();
            n++;
            check_equal("ram_wren", ram_wren, 1'b1);
            check_equal("check_en", check_en, n <= LAST_ADDR + 1);
            check_equal("check_done", check_done, 1'b0);
        end
        check_wr  = 1'b0;
        n         = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            step();
            n++;
            if (check_done === 1'b1)
                done_seen = 1'b1;
            else if (n > DONE_TIMEOUT)
                fail_timeout("check done pulse never came");
        end
        check_equal("check done delay", n, 2);
        step();
        check_equal("check_done", check_done, 1'b0);
        edge_ofs = edge_ofs + addr_t'(CHK_ROT_STEP);

        ////////////////////////////////////////
        // variable phase datapath
        var_go = 1'b1;
        step();
        var_go = 1'b0;
        check_equal("state", state, ST_VAR);
        check_lanes('0, edge_ofs);
        check_equal("lram_addr", lram_addr, llr_ofs);
        c         = 0;
        done_seen = 1'b0;
        prev_msg  = '0;
        while (!done_seen) begin
            drive_node();
            step();
            c++;
            check_equal("hard_bit", hard_bit, exp_hard);
            check_equal("msg_out", msg_out, prev_msg);
            prev_msg = exp_msg;
            check_equal("ram_wren", ram_wren, (c >= VAR_WR_FIRST) && (c <= VAR_WR_LAST));
            check_equal("lram_wren", lram_wren, (c >= VAR_WR_FIRST) && (c <= VAR_WR_LAST));
            check_lanes('0, addr_t'(edge_ofs + c));
            check_equal("lram_addr", lram_addr, addr_t'(llr_ofs + c));
            if (var_done === 1'b1) begin
                check_equal("var done cycle", c, VAR_DONE_CYC);
                done_seen = 1'b1;
            end else if (c > VAR_TIMEOUT) begin
                fail_timeout("variable done pulse never came");
            end
        end
        step();
        check_equal("var_done", var_done, 1'b0);
        edge_ofs = edge_ofs + addr_t'(VAR_ROT_STEP);
        llr_ofs  = llr_ofs + addr_t'(LLR_ROT_STEP);

        // rotated offsets on the next entries
        chk_base = $random(seed);
        check_go = 1'b1;
        step();
        check_go = 1'b0;
        check_equal("state", state, ST_CHECK);
        check_lanes(chk_base, edge_ofs);
        held_msg = exp_msg;
        check_equal("msg_out", msg_out, held_msg);
        repeat (4) begin
            drive_node();
            step();
            check_equal("hard_bit", hard_bit, exp_hard);
            check_equal("msg_out held", msg_out, held_msg);
        end
        var_go = 1'b1;
        step();
        var_go = 1'b0;
        check_equal("state", state, ST_VAR);
        check_lanes('0, edge_ofs);
        check_equal("lram_addr", lram_addr, llr_ofs);
        check_go = 1'b1;
        step();
        check_go = 1'b0;
        check_equal("state", state, ST_CHECK);
        start = 1'b1;
        step();
        start = 1'b0;
        check_equal("state", state, ST_IDLE);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic reset_n_o
);
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // release on a falling edge away from the rising edge
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

// File: src/vpu_top.sv
`timescale 1ns/1ps

module vpu_top (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic                                        start_i,
    input  logic                                        load_en_i,
    input  logic                                        check_go_i,
    input  logic                                        var_go_i,
    input  logic                                        check_wr_i,
    input  logic [vpu_pkg::N_EDGE*vpu_pkg::ADDR_W-1:0] chk_base_i,
    input  logic [vpu_pkg::N_EDGE*vpu_pkg::MSG_W-1:0]  msg_i,
    input  vpu_pkg::msg_t                               llr_i,
    output logic [vpu_pkg::N_EDGE*vpu_pkg::MSG_W-1:0]  msg_o,
    output logic                                        hard_bit_o,
    output logic                                        check_en_o,
    output logic                                        check_done_o,
    output logic                                        var_done_o,
    output logic                                        ram_wren_o,
    output logic [vpu_pkg::N_EDGE*vpu_pkg::ADDR_W-1:0] ram_addr_o,
    output logic                                        lram_wren_o,
    output vpu_pkg::addr_t                              lram_addr_o,
    output vpu_pkg::vpu_state_e                         state_o
);

    vpu_ctrl_if ctl_bus ();

    vpu_ctrl u_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start_i),
        .load_en_i  (load_en_i),
        .check_go_i (check_go_i),
        .var_go_i   (var_go_i),
        .check_wr_i (check_wr_i),
        .check_en_o (check_en_o),
        .chk_done_o (check_done_o),
        .var_done_o (var_done_o),
        .ctl        (ctl_bus.ctrl)
    );

    vpu_addr_gen u_addr_gen (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_i),
        .check_go_i  (check_go_i),
        .var_go_i    (var_go_i),
        .chk_base_i  (chk_base_i),
        .ram_addr_o  (ram_addr_o),
        .lram_addr_o (lram_addr_o),
        .ctl         (ctl_bus.addr)
    );

    vpu_node_calc u_node_calc (
        .clk        (clk),
        .reset_n    (reset_n),
        .msg_i      (msg_i),
        .llr_i      (llr_i),
        .msg_o      (msg_o),
        .hard_bit_o (hard_bit_o),
        .ctl        (ctl_bus.calc)
    );

    assign ram_wren_o  = ctl_bus.ram_wren;
    assign lram_wren_o = ctl_bus.lram_wren;
    assign state_o     = ctl_bus.state;

endmodule

// File: src/vpu_node_calc.sv
`timescale 1ns/1ps

module vpu_node_calc (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic [vpu_pkg::N_EDGE*vpu_pkg::MSG_W-1:0] msg_i,
    input  vpu_pkg::msg_t                              llr_i,
    output logic [vpu_pkg::N_EDGE*vpu_pkg::MSG_W-1:0] msg_o,
    output logic                                       hard_bit_o,
    vpu_ctrl_if.calc                                   ctl
);
    import vpu_pkg::*;

    typedef logic signed [SUM_W-1:0] sum_t;

    msg_t [N_EDGE-1:0] msg_in;
    msg_t [N_EDGE-1:0] msg_q;
    sum_t              msg_s [N_EDGE];
    sum_t              sum_q [N_EDGE];
    sum_t              llr_s;
    sum_t              total_s;

    function automatic sum_t sm_to_signed(msg_t m);
        sum_t mag;
        mag = sum_t'(m[MSG_W-2:0]);
        return m[MSG_W-1] ? -mag : mag;
    endfunction

    // back to sign-magnitude with the magnitude clipped
    function automatic msg_t signed_to_sm(sum_t s);
        logic [SUM_W-1:0] mag;
        mag = s[SUM_W-1] ? -s : s;
        if (mag > SUM_W'(SAT_MAG))
            mag = SUM_W'(SAT_MAG);
        return {s[SUM_W-1], mag[MSG_W-2:0]};
    endfunction

    assign msg_in = msg_i;
    assign llr_s  = sum_t'(signed'(llr_i));

    // extrinsic sum is total minus own lane
    always_comb begin
        total_s = llr_s;
        for (int i = 0; i < N_EDGE; i++) begin
            msg_s[i] = sm_to_signed(msg_in[i]);
            total_s  = total_s + msg_s[i];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N_EDGE; i++)
                sum_q[i] <= '0;
            hard_bit_o <= 1'b0;
        end else begin
            for (int i = 0; i < N_EDGE; i++)
                sum_q[i] <= total_s - msg_s[i];
            hard_bit_o <= total_s[SUM_W-1];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            msg_q <= '0;
        end else if (ctl.state == ST_VAR) begin
            for (int i = 0; i < N_EDGE; i++)
                msg_q[i] <= signed_to_sm(sum_q[i]);
        end
    end

    assign msg_o = msg_q;

endmodule

// File: src/vpu_addr_gen.sv
`timescale 1ns/1ps

module vpu_addr_gen (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic                                        start_i,
    input  logic                                        check_go_i,
    input  logic                                        var_go_i,
    input  logic [vpu_pkg::N_EDGE*vpu_pkg::ADDR_W-1:0] chk_base_i,
    output logic [vpu_pkg::N_EDGE*vpu_pkg::ADDR_W-1:0] ram_addr_o,
    output vpu_pkg::addr_t                              lram_addr_o,
    vpu_ctrl_if.addr                                    ctl
);
    import vpu_pkg::*;

    addr_t [N_EDGE-1:0] lane_base;
    addr_t [N_EDGE-1:0] lane_q;
    addr_t              llr_addr_q;
    addr_t              edge_ofs_q;
    addr_t              llr_ofs_q;

    assign lane_base = chk_base_i;

    ////////////////////////////////////////
    // edge lane addresses wrapping at 256
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane_q <= '0;
        end else begin
            for (int i = 0; i < N_EDGE; i++) begin
                case (ctl.state)
                    ST_IDLE: begin
                        if (start_i)
                            lane_q[i] <= '0;
                    end
                    ST_LOAD: begin
                        if (check_go_i)
                            lane_q[i] <= lane_base[i] + edge_ofs_q;
                        else if (ctl.ram_wren)
                            lane_q[i] <= lane_q[i] + 1'b1;
                    end
                    ST_CHECK: begin
                        if (var_go_i)
                            lane_q[i] <= edge_ofs_q;
                        else
                            lane_q[i] <= lane_q[i] + 1'b1;
                    end
                    ST_VAR: begin
                        if (check_go_i)
                            lane_q[i] <= lane_base[i] + edge_ofs_q;
                        else
                            lane_q[i] <= lane_q[i] + 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // channel LLR address
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            llr_addr_q <= '0;
        end else begin
            case (ctl.state)
                ST_IDLE: begin
                    if (start_i)
                        llr_addr_q <= '0;
                end
                ST_LOAD: begin
                    if (ctl.lram_wren)
                        llr_addr_q <= llr_addr_q + 1'b1;
                end
                ST_CHECK: begin
                    if (var_go_i)
                        llr_addr_q <= llr_ofs_q;
                end
                ST_VAR: llr_addr_q <= llr_addr_q + 1'b1;
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // rotating base offsets
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            edge_ofs_q <= '0;
            llr_ofs_q  <= '0;
        end else if ((ctl.state == ST_IDLE) && start_i) begin
            edge_ofs_q <= '0;
            llr_ofs_q  <= '0;
        end else if (ctl.chk_done) begin
            edge_ofs_q <= edge_ofs_q + addr_t'(CHK_ROT_STEP);
        end else if (ctl.var_done) begin
            edge_ofs_q <= edge_ofs_q + addr_t'(VAR_ROT_STEP);
            llr_ofs_q  <= llr_ofs_q + addr_t'(LLR_ROT_STEP);
        end
    end

    assign ram_addr_o  = lane_q;
    assign lram_addr_o = llr_addr_q;

endmodule

// File: src/vpu_ctrl.sv
`timescale 1ns/1ps

module vpu_ctrl (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     start_i,
    input  logic     load_en_i,
    input  logic     check_go_i,
    input  logic     var_go_i,
    input  logic     check_wr_i,
    output logic     check_en_o,
    output logic     chk_done_o,
    output logic     var_done_o,
    vpu_ctrl_if.ctrl ctl
);
    import vpu_pkg::*;

    vpu_state_e state_q;
    vpu_state_e state_d;
    logic       ram_wren_q;
    logic       lram_wren_q;
    logic       var_req_q;
    logic [1:0] var_req_dly_q;
    logic       check_en_q;
    addr_t      cyc_cnt_q;
    addr_t      wr_cnt_q;
    logic       chk_done_q;
    logic       var_done_q;
    logic       in_idle;
    logic       in_load;
    logic       in_check;
    logic       in_var;
    logic       cnt_clear;
    logic       cyc_last;
    logic       wr_last;

    assign in_idle  = (state_q == ST_IDLE);
    assign in_load  = (state_q == ST_LOAD);
    assign in_check = (state_q == ST_CHECK);
    assign in_var   = (state_q == ST_VAR);

    ////////////////////////////////////////
    // phase state machine
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i)
                    state_d = ST_LOAD;
            end
            ST_LOAD: begin
                if (check_go_i)
                    state_d = ST_CHECK;
            end
            ST_CHECK: begin
                if (start_i)
                    state_d = ST_IDLE;
                else if (var_go_i)
                    state_d = ST_VAR;
            end
            ST_VAR: begin
                if (check_go_i)
                    state_d = ST_CHECK;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    ////////////////////////////////////////
    // write enables
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ram_wren_q  <= 1'b0;
            lram_wren_q <= 1'b0;
        end else begin
            case (state_q)
                ST_LOAD: begin
                    ram_wren_q  <= load_en_i;
                    lram_wren_q <= load_en_i;
                end
                ST_CHECK: begin
                    ram_wren_q  <= check_wr_i;
                    lram_wren_q <= 1'b0;
                end
                // memory read plus two calc stages ahead of the write
                ST_VAR: begin
                    ram_wren_q  <= var_req_dly_q[1];
                    lram_wren_q <= var_req_dly_q[1];
                end
                default: begin
                    ram_wren_q  <= 1'b0;
                    lram_wren_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            var_req_q     <= 1'b0;
            var_req_dly_q <= '0;
            check_en_q    <= 1'b0;
            check_en_o    <= 1'b0;
        end else begin
            if (in_check && var_go_i && !start_i)
                var_req_q <= 1'b1;
            else if (in_var && (check_go_i || cyc_last))
                var_req_q <= 1'b0;
            var_req_dly_q <= {var_req_dly_q[0], var_req_q};

            if ((in_load || in_var) && check_go_i)
                check_en_q <= 1'b1;
            else if (in_check && (start_i || cyc_last))
                check_en_q <= 1'b0;
            check_en_o <= check_en_q;
        end
    end

    ////////////////////////////////////////
    // phase counters and done pulses
    assign cnt_clear = (in_idle && start_i) || (in_load && check_go_i) ||
                       (in_check && (start_i || var_go_i)) || (in_var && check_go_i);
    assign cyc_last  = (cyc_cnt_q == addr_t'(LAST_ADDR));
    assign wr_last   = ram_wren_q && (wr_cnt_q == addr_t'(LAST_ADDR));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cyc_cnt_q <= '0;
            wr_cnt_q  <= '0;
        end else if (cnt_clear) begin
            cyc_cnt_q <= '0;
            wr_cnt_q  <= '0;
        end else if (in_check || in_var) begin
            cyc_cnt_q <= cyc_cnt_q + 1'b1;
            if (ram_wren_q)
                wr_cnt_q <= wr_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            chk_done_q <= 1'b0;
            var_done_q <= 1'b0;
            chk_done_o <= 1'b0;
            var_done_o <= 1'b0;
        end else begin
            chk_done_q <= in_check && wr_last;
            var_done_q <= in_var && wr_last;
            chk_done_o <= chk_done_q;
            var_done_o <= var_done_q;
        end
    end

    assign ctl.state     = state_q;
    assign ctl.ram_wren  = ram_wren_q;
    assign ctl.lram_wren = lram_wren_q;
    assign ctl.chk_done  = chk_done_q;
    assign ctl.var_done  = var_done_q;

endmodule

// File: src/vpu_ctrl_if.sv
`timescale 1ns/1ps

interface vpu_ctrl_if;
    import vpu_pkg::*;

    vpu_state_e state;
    logic       ram_wren;
    logic       lram_wren;
    logic       chk_done;
    logic       var_done;

    modport ctrl (
        output state, output ram_wren, output lram_wren, output chk_done, output var_done
    );
    modport addr (
        input state, input ram_wren, input lram_wren, input chk_done, input var_done
    );
    modport calc (input state);

endinterface

// File: src/vpu_pkg.sv
package vpu_pkg;

    // message and sum widths
    localparam int unsigned MSG_W  = 6;
    localparam int unsigned SUM_W  = 8;
    localparam int unsigned ADDR_W = 8;
    localparam int unsigned N_EDGE = 3;

    // one full sweep of a 256-entry memory
    localparam int unsigned LAST_ADDR = 255;

    // offset rotation per phase
    localparam int unsigned CHK_ROT_STEP = 5;
    localparam int unsigned VAR_ROT_STEP = 3;
    localparam int unsigned LLR_ROT_STEP = 2;

    localparam int unsigned SAT_MAG = 31;

    typedef enum logic [3:0] {
        ST_IDLE  = 4'b0001,
        ST_LOAD  = 4'b0010,
        ST_CHECK = 4'b0100,
        ST_VAR   = 4'b1000
    } vpu_state_e;

    typedef logic [MSG_W-1:0]  msg_t;
    typedef logic [ADDR_W-1:0] addr_t;

endpackage
